/* vdcPkg.sv */
`default_nettype none

package vdcPkg;

	localparam int regAddrWidth = 4; // apb word index
	localparam int regDataWidth = 16;
	localparam int vramDataWidth = 8; // vram is byte wide
	localparam int dotsPerCol = 8; // pixels per character column

	typedef struct packed {
		logic [7:0] hTotal; // columns per line minus 1
		logic [7:0] hDisplayed;
		logic [7:0] hSyncPos; // first hsync column
		logic [3:0] hSyncWidth; // in columns
		logic [7:0] vTotal; // rows per frame minus 1
		logic [7:0] vDisplayed;
		logic [7:0] vSyncPos; // vsync row
		logic [3:0] vSyncWidth; // in scanlines
		logic [3:0] charTotalV; // scanlines per row minus 1
		logic [15:0] screenBase; // start of screen codes
		logic [1:0] fontBase; // top two vram address bits
		logic [3:0] fg;
		logic [3:0] bg;
		logic enable; // timing runs while set
	} vdcCfg_t;

	typedef enum logic [regAddrWidth-1:0] {
		regHTotal = 4'd0,
		regHDisplayed = 4'd1,
		regHSyncPos = 4'd2,
		regSyncWidth = 4'd3, // vsync width high nibble, hsync low
		regVTotal = 4'd4,
		regVDisplayed = 4'd5,
		regVSyncPos = 4'd6,
		regCharTotalV = 4'd7,
		regScreenBase = 4'd8,
		regFontBase = 4'd9,
		regColour = 4'd10, // fg high nibble, bg low
		regCtrl = 4'd11, // bit 0 enable
		regVramAddr = 4'd12, // cpu vram pointer
		regVramData = 4'd13 // data port, auto increments the pointer
	} regIndex_e;

endpackage

`default_nettype wire

/* vramIf.sv */
`default_nettype none

interface vramIf import vdcPkg::*; #(
	parameter int vramAddrWidth = 14
) ();

	logic req; // held until gnt
	logic we;
	logic [vramAddrWidth-1:0] addr;
	logic [vramDataWidth-1:0] wdata;
	logic gnt; // same cycle as the ram access
	logic [vramDataWidth-1:0] rdata; // valid the cycle after gnt

	modport requester (
		output req, we, addr, wdata,
		input gnt, rdata
	);

	modport arbiter (
		input req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

`default_nettype wire

/* vdcRegs.sv */
`default_nettype none

module vdcRegs import vdcPkg::*; #(
	parameter int vramAddrWidth = 14
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [regAddrWidth-1:0] paddr,
	input wire logic [regDataWidth-1:0] pwdata,
	output logic [regDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output vdcCfg_t cfg,
	vramIf.requester mem
);

	logic access; // apb access phase
	logic dataAcc; // access phase on the data port
	logic regWr;
	logic launch; // start a vram request
	logic reqPend; // waiting for grant
	logic rdValid; // read byte on mem.rdata
	logic wrDone;
	logic memWe;
	logic [vramDataWidth-1:0] memWdata;
	logic [vramAddrWidth-1:0] vramAddr;

	assign access = psel & penable;
	assign dataAcc = access & (paddr == regVramData);
	assign regWr = access & pwrite & (paddr != regVramData);
	assign launch = dataAcc & ~reqPend & ~rdValid; // one shot per transfer
	assign wrDone = reqPend & mem.gnt & memWe;

	assign mem.req = reqPend;
	assign mem.we = memWe;
	assign mem.addr = vramAddr;
	assign mem.wdata = memWdata;

	assign pready = dataAcc ? (wrDone | rdValid) : 1'b1; // regs are zero wait
	assign pslverr = 1'b0;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			cfg <= '0;
			reqPend <= 1'b0;
			rdValid <= 1'b0;
			vramAddr <= '0;
		end else begin
			rdValid <= reqPend & mem.gnt & ~memWe; // byte arrives after the grant
			if (launch) begin
				reqPend <= 1'b1;
			end else if (mem.gnt) begin
				reqPend <= 1'b0;
			end
			if (wrDone | rdValid) begin
				vramAddr <= vramAddr + 1'b1; // auto increment on completion
			end
			if (regWr) begin
				case (paddr)
					regHTotal: cfg.hTotal <= pwdata[7:0];
					regHDisplayed: cfg.hDisplayed <= pwdata[7:0];
					regHSyncPos: cfg.hSyncPos <= pwdata[7:0];
					regSyncWidth: {cfg.vSyncWidth, cfg.hSyncWidth} <= pwdata[7:0];
					regVTotal: cfg.vTotal <= pwdata[7:0];
					regVDisplayed: cfg.vDisplayed <= pwdata[7:0];
					regVSyncPos: cfg.vSyncPos <= pwdata[7:0];
					regCharTotalV: cfg.charTotalV <= pwdata[3:0];
					regScreenBase: cfg.screenBase <= pwdata;
					regFontBase: cfg.fontBase <= pwdata[1:0];
					regColour: {cfg.fg, cfg.bg} <= pwdata[7:0];
					regCtrl: cfg.enable <= pwdata[0];
					regVramAddr: vramAddr <= pwdata[vramAddrWidth-1:0];
					default: ; // unused indices ignored
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			memWe <= pwrite; // direction and byte held for the request
			memWdata <= pwdata[vramDataWidth-1:0];
		end
	end

	always_comb begin
		case (paddr)
			regHTotal: prdata = regDataWidth'(cfg.hTotal);
			regHDisplayed: prdata = regDataWidth'(cfg.hDisplayed);
			regHSyncPos: prdata = regDataWidth'(cfg.hSyncPos);
			regSyncWidth: prdata = regDataWidth'({cfg.vSyncWidth, cfg.hSyncWidth});
			regVTotal: prdata = regDataWidth'(cfg.vTotal);
			regVDisplayed: prdata = regDataWidth'(cfg.vDisplayed);
			regVSyncPos: prdata = regDataWidth'(cfg.vSyncPos);
			regCharTotalV: prdata = regDataWidth'(cfg.charTotalV);
			regScreenBase: prdata = cfg.screenBase;
			regFontBase: prdata = regDataWidth'(cfg.fontBase);
			regColour: prdata = regDataWidth'({cfg.fg, cfg.bg});
			regCtrl: prdata = regDataWidth'(cfg.enable);
			regVramAddr: prdata = regDataWidth'(vramAddr);
			regVramData: prdata = regDataWidth'(mem.rdata); // sampled with rdValid
			default: prdata = '0;
		endcase
	end

	// a granted request drops at once, so no second one overlaps it
	assert property (@(posedge clk) disable iff (!rstN) mem.req && mem.gnt |=> !mem.req);

	assert property (@(posedge clk) disable iff (!rstN)
		mem.req && !mem.gnt |=> mem.req && $stable(mem.addr) && $stable(mem.we)); // held until gnt

endmodule

`default_nettype wire

/* vdcTiming.sv */
`default_nettype none

module vdcTiming import vdcPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire vdcCfg_t cfg,
	output logic colStart,
	output logic [7:0] col,
	output logic [7:0] row,
	output logic [3:0] line,
	output logic visible,
	output logic hsyncRaw,
	output logic vsyncRaw
);

	localparam int dotWidth = $clog2(dotsPerCol);

	logic [dotWidth-1:0] dot; // pixel within column
	logic [3:0] vsCnt; // vsync scanlines left
	logic dotLast;
	logic colLast;
	logic lineLast;
	logic rowLast;
	logic [3:0] nextLine;
	logic [7:0] nextRow;
	logic [8:0] hSyncEnd; // first column past hsync

	assign dotLast = dot == dotWidth'(dotsPerCol - 1);
	assign colLast = col >= cfg.hTotal;
	assign lineLast = line >= cfg.charTotalV;
	assign rowLast = row >= cfg.vTotal;
	assign nextLine = lineLast ? 4'd0 : line + 1'b1;
	assign nextRow = !lineLast ? row : (rowLast ? 8'd0 : row + 1'b1);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dot <= '0;
			col <= '0;
			line <= '0;
			row <= '0;
			vsCnt <= '0;
		end else if (!cfg.enable) begin
			dot <= '0; // counters held clear
			col <= '0;
			line <= '0;
			row <= '0;
			vsCnt <= (cfg.vSyncPos == 8'd0) ? cfg.vSyncWidth : 4'd0; // frame opens on row 0
		end else begin
			dot <= dotLast ? '0 : dot + 1'b1;
			if (dotLast) begin
				if (colLast) begin
					col <= '0; // end of scanline
					line <= nextLine;
					row <= nextRow;
					if (nextRow == cfg.vSyncPos && nextLine == 4'd0) begin
						vsCnt <= cfg.vSyncWidth; // vsync from line 0 of the sync row
					end else if (vsCnt != 4'd0) begin
						vsCnt <= vsCnt - 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	assign colStart = cfg.enable & (dot == '0);
	assign hSyncEnd = {1'b0, cfg.hSyncPos} + 9'(cfg.hSyncWidth);
	assign hsyncRaw = cfg.enable & (col >= cfg.hSyncPos) & ({1'b0, col} < hSyncEnd);
	assign vsyncRaw = cfg.enable & (vsCnt != 4'd0);
	assign visible = cfg.enable & (col < cfg.hDisplayed) & (row < cfg.vDisplayed);

	// column count stays inside the programmed line
	assert property (@(posedge clk) disable iff (!rstN || !cfg.enable) col <= cfg.hTotal);

	// vsync only starts on the first column of a scanline
	assert property (@(posedge clk) disable iff (!rstN) $rose(vsyncRaw) |-> colStart && col == 8'd0);

endmodule

`default_nettype wire

/* vdcFetch.sv */
`default_nettype none

module vdcFetch import vdcPkg::*; #(
	parameter int vramAddrWidth = 14
) (
	input wire logic clk,
	input wire logic rstN,
	input wire vdcCfg_t cfg,
	input wire logic colStart,
	input wire logic [7:0] col,
	input wire logic [7:0] row,
	input wire logic [3:0] line,
	input wire logic visible,
	input wire logic hsyncRaw,
	input wire logic vsyncRaw,
	vramIf.requester mem,
	output logic [3:0] rgbi,
	output logic de,
	output logic hsync,
	output logic vsync
);

	localparam int dotWidth = $clog2(dotsPerCol);

	logic [dotWidth-1:0] dot;
	logic [dotWidth-1:0] dotQ;
	logic [15:0] rowBase; // screen offset of the current row
	logic rowEnd;
	logic codeReq;
	logic fontReq;
	logic [vramAddrWidth-1:0] codeAddr;
	logic [vramAddrWidth-1:0] fontAddr;
	logic [vramDataWidth-1:0] codeQ;
	logic [vramDataWidth-1:0] fontQ;
	logic [vramDataWidth-1:0] shiftQ; // pixels of the displayed column
	logic [dotsPerCol-1:0] visD; // one column of delay
	logic [dotsPerCol-1:0] hsD;
	logic [dotsPerCol-1:0] vsD;

	assign dot = colStart ? '0 : dotQ; // realigned on every column
	assign codeReq = colStart & visible;
	assign fontReq = visible & (dot == dotWidth'(2));
	assign rowEnd = colStart & (col >= cfg.hTotal) & (line >= cfg.charTotalV);

	assign codeAddr = vramAddrWidth'(cfg.screenBase + rowBase + 16'(col));
	assign fontAddr = (vramAddrWidth'(cfg.fontBase) << (vramAddrWidth - 2))
		| vramAddrWidth'({codeQ, line}); // font, code, scanline

	assign mem.req = codeReq | fontReq;
	assign mem.we = 1'b0; // display only reads
	assign mem.addr = fontReq ? fontAddr : codeAddr;
	assign mem.wdata = '0;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dotQ <= '0;
			rowBase <= '0;
			visD <= '0;
			hsD <= '0;
			vsD <= '0;
		end else begin
			dotQ <= dot + 1'b1;
			visD <= {visD[dotsPerCol-2:0], visible};
			hsD <= {hsD[dotsPerCol-2:0], hsyncRaw};
			vsD <= {vsD[dotsPerCol-2:0], vsyncRaw};
			if (!cfg.enable) begin
				rowBase <= '0;
			end else if (rowEnd) begin
				rowBase <= (row >= cfg.vTotal) ? 16'd0 : rowBase + 16'(cfg.hDisplayed);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dot == dotWidth'(1)) begin
			codeQ <= mem.rdata; // screen code
		end
		if (dot == dotWidth'(3)) begin
			fontQ <= mem.rdata; // font byte
		end
		if (dot == dotWidth'(dotsPerCol - 1)) begin
			shiftQ <= fontQ; // shows from the next colStart
		end else begin
			shiftQ <= shiftQ << 1; // msb first
		end
	end

	assign de = visD[dotsPerCol-1];
	assign hsync = hsD[dotsPerCol-1];
	assign vsync = vsD[dotsPerCol-1];
	assign rgbi = !de ? 4'd0 : (shiftQ[vramDataWidth-1] ? cfg.fg : cfg.bg);

	// display has priority, so fetches never wait
	assert property (@(posedge clk) disable iff (!rstN) mem.req |-> mem.gnt);

	assert property (@(posedge clk) disable iff (!rstN) fontReq |-> $past(codeReq, 2));

endmodule

`default_nettype wire

/* vramArbiter.sv */
`default_nettype none

module vramArbiter import vdcPkg::*; #(
	parameter int vramAddrWidth = 14
) (
	input wire logic clk,
	input wire logic rstN,
	vramIf.arbiter disp,
	vramIf.arbiter cpu,
	output logic ramEn,
	output logic ramWe,
	output logic [vramAddrWidth-1:0] ramAddr,
	output logic [vramDataWidth-1:0] ramWdata,
	input wire logic [vramDataWidth-1:0] ramRdata
);

	logic dispSel;
	logic cpuSel;
	logic dispSelQ; // owner of the byte now on ramRdata
	logic cpuSelQ;

	assign dispSel = disp.req; // display always wins
	assign cpuSel = cpu.req & ~disp.req;
	assign disp.gnt = dispSel;
	assign cpu.gnt = cpuSel;

	assign ramEn = dispSel | cpuSel;
	assign ramWe = dispSel ? disp.we : cpu.we;
	assign ramAddr = dispSel ? disp.addr : cpu.addr;
	assign ramWdata = dispSel ? disp.wdata : cpu.wdata;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dispSelQ <= 1'b0;
			cpuSelQ <= 1'b0;
		end else begin
			dispSelQ <= dispSel;
			cpuSelQ <= cpuSel;
		end
	end

	assign disp.rdata = dispSelQ ? ramRdata : '0; // steer read data back
	assign cpu.rdata = cpuSelQ ? ramRdata : '0;

	assert property (@(posedge clk) disable iff (!rstN) !(disp.gnt && cpu.gnt)); // no dual grant

endmodule

`default_nettype wire

/* vram.sv */
`default_nettype none

module vram import vdcPkg::*; #(
	parameter int vramAddrWidth = 14
) (
	input wire logic clk,
	input wire logic en,
	input wire logic we,
	input wire logic [vramAddrWidth-1:0] addr,
	input wire logic [vramDataWidth-1:0] wdata,
	output logic [vramDataWidth-1:0] rdata
);

	logic [vramDataWidth-1:0] mem [2**vramAddrWidth]; // one byte per location

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end
			rdata <= mem[addr]; // one cycle latency, old data on write
		end
	end

endmodule

`default_nettype wire

/* vdcTop.sv */
`default_nettype none

module vdcTop import vdcPkg::*; #(
	parameter int vramAddrWidth = 14
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [regAddrWidth-1:0] paddr,
	input wire logic [regDataWidth-1:0] pwdata,
	output logic [regDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [3:0] rgbi,
	output logic de,
	output logic hsync,
	output logic vsync
);

	vdcCfg_t cfg; // programmed configuration
	logic colStart;
	logic [7:0] col;
	logic [7:0] row;
	logic [3:0] line;
	logic visible;
	logic hsyncRaw;
	logic vsyncRaw;
	logic ramEn;
	logic ramWe;
	logic [vramAddrWidth-1:0] ramAddr;
	logic [vramDataWidth-1:0] ramWdata;
	logic [vramDataWidth-1:0] ramRdata;

	vramIf #(.vramAddrWidth(vramAddrWidth)) dispBus (); // fetcher side
	vramIf #(.vramAddrWidth(vramAddrWidth)) cpuBus (); // apb side

	vdcRegs #(.vramAddrWidth(vramAddrWidth)) uRegs (
		.clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .cfg(cfg), .mem(cpuBus.requester)
	);

	vdcTiming uTiming (
		.clk(clk), .rstN(rstN), .cfg(cfg), .colStart(colStart), .col(col), .row(row),
		.line(line), .visible(visible), .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw)
	);

	vdcFetch #(.vramAddrWidth(vramAddrWidth)) uFetch (
		.clk(clk), .rstN(rstN), .cfg(cfg), .colStart(colStart), .col(col), .row(row),
		.line(line), .visible(visible), .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw),
		.mem(dispBus.requester), .rgbi(rgbi), .de(de), .hsync(hsync), .vsync(vsync)
	);

	vramArbiter #(.vramAddrWidth(vramAddrWidth)) uArbiter (
		.clk(clk), .rstN(rstN), .disp(dispBus.arbiter), .cpu(cpuBus.arbiter),
		.ramEn(ramEn), .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata),
		.ramRdata(ramRdata)
	);

	vram #(.vramAddrWidth(vramAddrWidth)) uVram (
		.clk(clk), .en(ramEn), .we(ramWe), .addr(ramAddr), .wdata(ramWdata),
		.rdata(ramRdata)
	);

endmodule

`default_nettype wire

/* tbVdc.sv */
`default_nettype none

module tbVdc import vdcPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int addrW = 14;
	localparam int memSize = 2 ** addrW;
	localparam int apbLimit = 50; // cycles per apb transfer
	localparam int waitLimit = 20000; // longer than any frame
	localparam int sigHsync = 0;
	localparam int sigVsync = 1;
	localparam int sigDe = 2;

	logic clk;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [15:0] pwdata;
	logic [15:0] prdata;
	logic pready;
	logic pslverr;
	logic [3:0] rgbi;
	logic de;
	logic hsync;
	logic vsync;

	vdcCfg_t geo; // random geometry and colours
	logic [7:0] shadow [memSize]; // vram as written by the cpu
	string sigNames [3] = '{"hsync", "vsync", "de"};
	int errors;
	int testErrBase;
	int testsRun;
	int testsFailed;
	int lineClk; // clocks per scanline
	int dataBase; // area of the vram port tests

	vdcTop #(.vramAddrWidth(addrW)) u_dut (
		.clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .rgbi(rgbi), .de(de), .hsync(hsync), .vsync(vsync)
	);

	always #5 clk = ~clk;

	task automatic mismatch(input string name, input logic [15:0] expVal,
			input logic [15:0] actVal);
		errors++;
		$display("Error at %0t ns: %s expected %h actual %h", $time, name, expVal, actVal);
	endtask

	task automatic failure(input string what);
		errors++;
		$display("%s at %0t ns", what, $time);
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errors != testErrBase) begin
			testsFailed++;
			$display("test %s: FAILED, %0d errors", name, errors - testErrBase);
		end else begin
			$display("test %s: ok", name);
		end
		testErrBase = errors;
	endtask

	// called 1 ns after a rising edge, returns 1 ns after the completing edge
	task automatic apbXfer(input logic wr, input logic [3:0] addr, input logic [15:0] wdata,
			output logic [15:0] rdata);
		int n;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1 penable = 1'b1;
		for (n = 0; n < apbLimit; n++) begin
			@(posedge clk);
			if (pready === 1'b1) break;
		end
		rdata = prdata;
		if (n == apbLimit) failure($sformatf("APB transfer to index %0d never completed", addr));
		if (pslverr !== 1'b0) mismatch("pslverr", 16'd0, 16'(pslverr)); // never an error
		#1 psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic regWrite(input logic [3:0] addr, input logic [15:0] data);
		logic [15:0] ignored;
		apbXfer(1'b1, addr, data, ignored);
	endtask

	task automatic waitLevel(input int which, input logic level, output int n);
		logic now;
		for (n = 1; n <= waitLimit; n++) begin
			@(posedge clk);
			now = (which == sigHsync) ? hsync : ((which == sigVsync) ? vsync : de);
			if (now === level) break;
		end
		if (n > waitLimit) failure($sformatf("%s never went to %b", sigNames[which], level));
		#1; // back to the drive point
	endtask

	task automatic measurePulse(input int which, output int width, output int period);
		int n;
		waitLevel(which, 1'b0, n);
		waitLevel(which, 1'b1, n); // aligned to a rising edge
		waitLevel(which, 1'b0, width);
		waitLevel(which, 1'b1, period);
		period += width;
	endtask

	task automatic vramLoad(input int start, input int count, input int range);
		logic [7:0] b;
		int i;
		regWrite(regVramAddr, 16'(start));
		for (i = 0; i < count; i++) begin
			b = 8'($urandom % range);
			shadow[(start + i) % memSize] = b;
			regWrite(regVramData, 16'(b)); // pointer steps by itself
		end
	endtask

	task automatic vramCheck(input int start, input int count);
		logic [15:0] rd;
		int i;
		regWrite(regVramAddr, 16'(start));
		for (i = 0; i < count; i++) begin
			apbXfer(1'b0, regVramData, 16'd0, rd);
			if (rd !== 16'(shadow[(start + i) % memSize])) begin
				mismatch($sformatf("prdata of vram %0h", (start + i) % memSize),
					16'(shadow[(start + i) % memSize]), rd);
			end
		end
	endtask

	task automatic pickGeometry();
		geo = '0;
		geo.hTotal = 8'(12 + $urandom % 9);
		geo.hDisplayed = 8'(4 + $urandom % 5);
		geo.hSyncPos = geo.hDisplayed + 8'(1 + $urandom % 2); // right of the text
		geo.hSyncWidth = 4'(1 + $urandom % 2);
		geo.vTotal = 8'(5 + $urandom % 4);
		geo.vDisplayed = 8'(2 + $urandom % 3);
		geo.vSyncPos = geo.vDisplayed + 8'd1; // below the text
		geo.vSyncWidth = 4'(1 + $urandom % 3);
		geo.charTotalV = 4'(3 + $urandom % 5);
		geo.screenBase = 16'($urandom % 256);
		geo.fontBase = 2'(1 + $urandom % 3); // font never overlaps screen codes
		geo.fg = 4'($urandom);
		geo.bg = geo.fg ^ 4'(1 + $urandom % 15);
		geo.enable = 1'b1;
		lineClk = (int'(geo.hTotal) + 1) * dotsPerCol;
	endtask

	task automatic checkFrame();
		int frame;
		int pix;
		int i;
		int x;
		int s;
		int lines;
		int hdDots;
		logic [7:0] code;
		logic [7:0] font;
		logic [3:0] expRgbi;
		lines = int'(geo.charTotalV) + 1;
		hdDots = int'(geo.hDisplayed) * dotsPerCol;
		frame = (int'(geo.vTotal) + 1) * lines * lineClk;
		pix = 0;
		waitLevel(sigVsync, 1'b1, i);
		waitLevel(sigVsync, 1'b0, i); // count from the vsync fall
		for (i = 0; i < frame; i++) begin
			@(posedge clk);
			if (de === 1'b1) begin
				x = pix % hdDots; // dot inside the scanline
				s = pix / hdDots; // scanline inside the text area
				code = shadow[(int'(geo.screenBase) + (s / lines) * int'(geo.hDisplayed)
					+ x / dotsPerCol) % memSize];
				font = shadow[(int'(geo.fontBase) << (addrW - 2)) + int'(code) * 16 + s % lines];
				expRgbi = font[7 - x % dotsPerCol] ? geo.fg : geo.bg; // msb leftmost
				if (rgbi !== expRgbi) begin
					mismatch($sformatf("rgbi at pixel %0d", pix), 16'(expRgbi), 16'(rgbi));
				end
				pix++;
			end else if (rgbi !== 4'd0) begin
				mismatch("rgbi while de low", 16'd0, 16'(rgbi));
			end
		end
		if (pix != hdDots * lines * int'(geo.vDisplayed)) begin
			mismatch("de pixel count", 16'(hdDots * lines * int'(geo.vDisplayed)), 16'(pix));
		end
	endtask

	initial begin
		logic [15:0] regVals [12];
		logic [15:0] rd;
		int i;
		int width;
		int period;
		clk = 1'b0;
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errors = 0;
		testErrBase = 0;
		testsRun = 0;
		testsFailed = 0;
		void'($urandom(32'h81c56add));
		pickGeometry();
		dataBase = 16'h0800 + $urandom % 1024;
		repeat (16) @(posedge clk);
		#1 rstN = 1'b1;

		vramLoad(int'(geo.screenBase), int'(geo.hDisplayed) * int'(geo.vDisplayed), 8);
		vramLoad(int'(geo.fontBase) << (addrW - 2), 128, 256); // 16 lines per code

		regVals = '{16'(geo.hTotal), 16'(geo.hDisplayed), 16'(geo.hSyncPos),
			16'({geo.vSyncWidth, geo.hSyncWidth}), 16'(geo.vTotal), 16'(geo.vDisplayed),
			16'(geo.vSyncPos), 16'(geo.charTotalV), geo.screenBase, 16'(geo.fontBase),
			16'({geo.fg, geo.bg}), 16'(geo.enable)};
		for (i = 0; i < 12; i++) begin
			regWrite(4'(i), regVals[i]); // ctrl last, timing starts here
		end
		for (i = 0; i < 16; i++) begin
			apbXfer(1'b0, 4'(i), 16'd0, rd);
			if (i < 12 && rd !== regVals[i]) begin
				mismatch($sformatf("prdata of register %0d", i), regVals[i], rd);
			end else if (i >= 14 && rd !== 16'd0) begin
				mismatch($sformatf("prdata of unused index %0d", i), 16'd0, rd);
			end
		end
		endTest("register read-back");

		vramLoad(dataBase, 64, 256);
		vramCheck(dataBase, 64);
		endTest("vram port");

		measurePulse(sigHsync, width, period);
		if (width != int'(geo.hSyncWidth) * dotsPerCol) begin
			mismatch("hsync width", 16'(int'(geo.hSyncWidth) * dotsPerCol), 16'(width));
		end
		if (period != lineClk) mismatch("hsync period", 16'(lineClk), 16'(period));
		endTest("horizontal timing");

		measurePulse(sigVsync, width, period);
		if (width != int'(geo.vSyncWidth) * lineClk) begin
			mismatch("vsync width", 16'(int'(geo.vSyncWidth) * lineClk), 16'(width));
		end
		if (period != (int'(geo.vTotal) + 1) * (int'(geo.charTotalV) + 1) * lineClk) begin
			mismatch("vsync period",
				16'((int'(geo.vTotal) + 1) * (int'(geo.charTotalV) + 1) * lineClk), 16'(period));
		end
		endTest("vertical timing");

		checkFrame();
		endTest("pixels");

		for (i = 0; i < 4; i++) begin
			waitLevel(sigDe, 1'b0, width);
			waitLevel(sigDe, 1'b1, width); // reads overlap the fetches
			vramCheck(dataBase + 16 * i, 16);
		end
		endTest("contention");

		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
vdcPkg.sv
vramIf.sv
vdcRegs.sv
vdcTiming.sv
vdcFetch.sv
vramArbiter.sv
vram.sv
vdcTop.sv
tbVdc.sv

/* run.sh */
#!/bin/sh
# builds the testbench with verilator, runs it and searches the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbVdc -f project.f -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^All checks passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
